// File: sim.f
design/dist_sample_pkg.sv
design/dist_regs_pkg.sv
design/dist_csr.sv
design/dist_region_decode.sv
design/dist_shaper.sv
design/dist_output_stage.sv
design/dist_top.sv
verif/dist_props.sv
verif/dist_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dist_tb -f sim.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vdist_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" <<< "$output"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verif/dist_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dist_tb import dist_sample_pkg::*, dist_regs_pkg::*; ();

    localparam int TIMEOUT = 2000;

    // one expected output and the edge count at which its input was accepted.
    typedef struct packed {
        logic [SAMPLE_W-1:0] data;
        logic                clipped;
        logic                lat_check;
        logic [31:0]         cycle;
    } exp_entry_t;

    logic                clk;
    logic                reset;
    logic [ADDR_W-1:0]   awaddr, araddr;
    logic [DATA_W-1:0]   wdata, rdata;
    logic [STRB_W-1:0]   wstrb;
    logic [1:0]          bresp, rresp;
    logic                awvalid, awready, wvalid, wready, bvalid, bready;
    logic                arvalid, arready, rvalid, rready;
    logic [SAMPLE_W-1:0] s_tdata, m_tdata;
    logic                s_tvalid, s_tready, m_tvalid, m_tready;

    exp_entry_t  exp_q[$];
    dist_cfg_t   model_cfg;
    logic [31:0] rng;
    logic [31:0] cycle;
    logic [31:0] clip_expected;
    logic        rand_ready;
    logic        lat_phase;
    int          checks = 0;
    int          mismatches = 0;
    int          other_errors = 0;

    dist_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] next_random();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // the consumer is either always ready or ready on a random subset of cycles.
    always @(posedge clk) begin
        #1;
        m_tready = !rand_ready || (next_random() > 32'h6000_0000);
    end

    function automatic exp_entry_t predict(input logic [31:0] s, input dist_cfg_t c);
        longint     sv;
        longint     lim;
        longint     thr;
        longint     res;
        exp_entry_t e;
        sv  = longint'($signed(s));
        lim = longint'(c.high_clip);
        thr = longint'(c.cross_thresh);
        e   = '0;
        e.clipped = (sv > lim) || (sv < -lim);
        res = (sv > lim) ? lim :
              (sv < -lim) ? -lim :
              (c.cross_en && sv > -thr && sv < thr) ? sv * (64'sd1 << c.cross_shift) : sv;
        e.data = res[31:0];
        return e;
    endfunction

    function automatic logic [31:0] random_sample(input logic in_window);
        logic [31:0] r;
        logic [31:0] s;
        r = next_random();
        s = next_random();
        if (in_window) begin
            return (r % (2 * model_cfg.cross_thresh - 1)) - model_cfg.cross_thresh + 1;
        end
        return $signed(r) >>> s[4:0];
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h", name, got, want);
        end
    endtask

    // Transfers are sampled at the falling edge, where every input is settled.
    always @(negedge clk) begin : monitor
        exp_entry_t e;
        if (!reset && s_tvalid && s_tready) begin
            e = predict(s_tdata, model_cfg);
            e.lat_check = lat_phase;
            e.cycle = cycle;
            exp_q.push_back(e);
        end
        if (!reset && m_tvalid && m_tready) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("output transfer with no sample outstanding");
            end else begin
                e = exp_q.pop_front();
                check_eq("m_tdata", m_tdata, e.data);
                clip_expected += e.clipped;
                if (e.lat_check) begin
                    check_eq("latency", cycle - e.cycle, 32'd3);
                end
            end
        end
    end

    task automatic finish_run();
        int props_fails;
        props_fails = u_dut.u_props.fail_count;
        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 checks, mismatches, other_errors, props_fails);
        if (mismatches + other_errors + props_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic abort_run(input string what);
        other_errors++;
        $display("timeout while waiting for %s", what);
        finish_run();
    endtask

    function automatic logic handshake_up(input string what);
        case (what)
            "awready": return awready && wready;
            "bvalid":  return bvalid;
            "arready": return arready;
            "rvalid":  return rvalid;
            default:   return s_tready;
        endcase
    endfunction

    task automatic wait_high(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!handshake_up(what) && (waited <= TIMEOUT)) begin
            waited++;
            @(negedge clk);
        end
        if (!handshake_up(what)) begin
            abort_run(what);
        end
    endtask

    task automatic send_sample(input logic [SAMPLE_W-1:0] d);
        @(posedge clk);
        #1;
        s_tdata  = d;
        s_tvalid = 1'b1;
        wait_high("s_tready");
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        s_tvalid = 1'b0;
        while ((exp_q.size() != 0) && (waited <= TIMEOUT)) begin
            waited++;
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            abort_run("the pipeline to drain");
        end
    endtask

    // bready comes one cycle late so the response has to hold for a cycle.
    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb, input logic [1:0] want_resp);
        @(posedge clk);
        #1;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        wait_high("awready");
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_high("bvalid");
        @(posedge clk);
        #1;
        bready = 1'b1;
        @(negedge clk);
        check_eq("bresp", bresp, want_resp);
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] want,
                            input logic [1:0] want_resp);
        @(posedge clk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        wait_high("arready");
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        wait_high("rvalid");
        @(posedge clk);
        #1;
        rready = 1'b1;
        @(negedge clk);
        check_eq("rdata", rdata, want);
        check_eq("rresp", rresp, want_resp);
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
        {araddr, arvalid, rready, s_tdata, s_tvalid} = '0;
        m_tready      = 1'b1;
        rng           = 32'h6d62;
        cycle         = '0;
        clip_expected = '0;
        rand_ready    = 1'b0;
        lat_phase     = 1'b0;
        model_cfg     = '{cross_en: 1'b1, high_clip: 32'h0010_0000,
                          cross_thresh: 32'h0000_1000, cross_shift: 3'd4};
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        read_reg(REG_CTRL, 32'h1, RESP_OKAY);
        read_reg(REG_HIGH_CLIP, 32'h0010_0000, RESP_OKAY);
        read_reg(REG_CROSS_THRESH, 32'h0000_1000, RESP_OKAY);
        read_reg(REG_CROSS_SHIFT, 32'h4, RESP_OKAY);
        read_reg(REG_CLIP_COUNT, 32'h0, RESP_OKAY);
        write_reg(REG_HIGH_CLIP, 32'hAABB_CCDD, 4'b0101, RESP_OKAY);
        read_reg(REG_HIGH_CLIP, 32'h00BB_00DD, RESP_OKAY);
        write_reg(REG_CTRL, 32'h0, 4'b0000, RESP_OKAY);
        read_reg(REG_CTRL, 32'h1, RESP_OKAY);
        write_reg(REG_CROSS_THRESH, 32'h1234_0800, 4'b0011, RESP_OKAY);
        read_reg(REG_CROSS_THRESH, 32'h0000_0800, RESP_OKAY);
        write_reg(REG_CROSS_SHIFT, 32'hFFFF_FF03, 4'b0001, RESP_OKAY);
        read_reg(REG_CROSS_SHIFT, 32'h3, RESP_OKAY);
        write_reg(REG_HIGH_CLIP, 32'h0008_0000, 4'b1111, RESP_OKAY);
        model_cfg.high_clip    = 32'h0008_0000;
        model_cfg.cross_thresh = 32'h0000_0800;
        model_cfg.cross_shift  = 3'd3;

        // Both edges of the clip window come first, with the consumer always ready.
        lat_phase = 1'b1;
        send_sample(32'h0008_0000);
        send_sample(32'h0008_0001);
        send_sample(32'hFFF8_0000);
        send_sample(32'hFFF7_FFFF);
        for (int i = 0; i < 60; i++) begin
            send_sample(random_sample(1'b0));
        end
        drain();
        lat_phase  = 1'b0;
        rand_ready = 1'b1;
        for (int i = 0; i < 200; i++) begin
            send_sample(random_sample(1'b0));
        end
        rand_ready = 1'b0;
        drain();

        send_sample(32'h0000_0800);
        send_sample(32'hFFFF_F800);
        for (int i = 0; i < 40; i++) begin
            send_sample(random_sample(1'b1));
        end
        drain();
        write_reg(REG_CTRL, 32'h0, 4'b0001, RESP_OKAY);
        model_cfg.cross_en = 1'b0;
        for (int i = 0; i < 40; i++) begin
            send_sample(random_sample(1'b1));
        end
        drain();

        read_reg(REG_CLIP_COUNT, clip_expected, RESP_OKAY);
        write_reg(REG_CLIP_COUNT, 32'h0, 4'b1111, RESP_SLVERR);
        read_reg(REG_CLIP_COUNT, clip_expected, RESP_OKAY);
        write_reg(8'h24, 32'hFFFF_FFFF, 4'b1111, RESP_SLVERR);
        read_reg(8'h20, 32'h0, RESP_SLVERR);
        finish_run();
    end

endmodule

`default_nettype wire

// File: verif/dist_props.sv
`timescale 1ns/1ns
`default_nettype none

module dist_props import dist_sample_pkg::*; (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [SAMPLE_W-1:0] m_tdata,
    input  wire logic                m_tvalid,
    input  wire logic                m_tready,
    input  wire dist_decoded_t       decoded,
    input  wire dist_shaped_t        shaped,
    input  wire logic                bvalid,
    input  wire logic                bready,
    input  wire logic                rvalid,
    input  wire logic                rready
);

    int fail_count = 0;

    // a stalled output keeps both its valid and its data until it is taken.
    stall_hold: assert property (@(posedge clk) disable iff (reset)
            m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata))
        else begin
            $error("m_tvalid or m_tdata changed while the output was stalled");
            fail_count++;
        end

    // the earlier stages freeze together with the output.
    stall_input: assert property (@(posedge clk) disable iff (reset)
            m_tvalid && !m_tready |=> $stable(decoded) && $stable(shaped))
        else begin
            $error("a pipeline stage moved while the output was stalled");
            fail_count++;
        end

    bresp_hold: assert property (@(posedge clk) disable iff (reset)
            bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    rdata_hold: assert property (@(posedge clk) disable iff (reset)
            rvalid && !rready |=> rvalid)
        else begin
            $error("rvalid dropped before rready");
            fail_count++;
        end

endmodule

bind dist_top dist_props u_props (
    .clk, .reset, .m_tdata, .m_tvalid, .m_tready, .decoded, .shaped,
    .bvalid, .bready, .rvalid, .rready
);

`default_nettype wire

// File: design/dist_top.sv
`timescale 1ns/1ns
`default_nettype none

module dist_top import dist_sample_pkg::*, dist_regs_pkg::*; #(
    parameter logic [DATA_W-1:0] DEFAULT_HIGH_CLIP    = 32'h0010_0000,
    parameter logic [DATA_W-1:0] DEFAULT_CROSS_THRESH = 32'h0000_1000,
    parameter logic [2:0]        DEFAULT_CROSS_SHIFT  = 3'd4
) (
    input  wire logic                       clk,
    input  wire logic                       reset,

    input  wire logic [ADDR_W-1:0]          awaddr,
    input  wire logic                       awvalid,
    output logic                            awready,
    input  wire logic [DATA_W-1:0]          wdata,
    input  wire logic [STRB_W-1:0]          wstrb,
    input  wire logic                       wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  wire logic                       bready,
    input  wire logic [ADDR_W-1:0]          araddr,
    input  wire logic                       arvalid,
    output logic                            arready,
    output logic [DATA_W-1:0]               rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  wire logic                       rready,

    input  wire logic signed [SAMPLE_W-1:0] s_tdata,
    input  wire logic                       s_tvalid,
    output logic                            s_tready,

    output logic signed [SAMPLE_W-1:0]      m_tdata,
    output logic                            m_tvalid,
    input  wire logic                       m_tready
);

    dist_cfg_t     cfg;
    dist_decoded_t decoded;
    dist_shaped_t  shaped;
    logic          clip_event;
    logic          advance;

    // The whole pipeline moves as one, so a stall at the output freezes
    // every stage and the input together.
    assign advance  = !m_tvalid || m_tready;
    assign s_tready = advance;

    dist_csr #(
        .DEFAULT_HIGH_CLIP    (DEFAULT_HIGH_CLIP),
        .DEFAULT_CROSS_THRESH (DEFAULT_CROSS_THRESH),
        .DEFAULT_CROSS_SHIFT  (DEFAULT_CROSS_SHIFT)
    ) u_csr (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .cfg, .clip_event
    );

    dist_region_decode u_decode (
        .clk, .reset, .advance, .s_tdata, .s_tvalid, .cfg, .decoded
    );

    dist_shaper u_shaper (
        .clk, .reset, .advance, .decoded, .shaped
    );

    dist_output_stage u_output (
        .clk, .reset, .advance, .shaped, .m_tdata, .m_tvalid, .m_tready, .clip_event
    );

endmodule

`default_nettype wire

// File: design/dist_output_stage.sv
`timescale 1ns/1ns
`default_nettype none

module dist_output_stage import dist_sample_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 advance,
    input  wire dist_shaped_t         shaped,
    output logic signed [SAMPLE_W-1:0] m_tdata,
    output logic                      m_tvalid,
    input  wire logic                 m_tready,
    output logic                      clip_event
);

    dist_shaped_t out_q;

    // advance stays low while the consumer stalls a valid output,
    // so the held sample cannot change under it.
    always_ff @(posedge clk) begin
        if (reset) begin
            out_q.valid <= 1'b0;
        end else if (advance) begin
            out_q <= shaped;
        end
    end

    assign m_tdata  = out_q.sample;
    assign m_tvalid = out_q.valid;

    // counted only once the clipped sample has really left the stage.
    assign clip_event = out_q.valid && m_tready && out_q.clipped;

endmodule

`default_nettype wire

// File: design/dist_shaper.sv
`timescale 1ns/1ns
`default_nettype none

module dist_shaper import dist_sample_pkg::*; (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          advance,
    input  wire dist_decoded_t decoded,
    output dist_shaped_t       shaped
);

    dist_shaped_t shaped_d;

    // The opcode alone selects the result because every comparison was made in decode.
    always_comb begin
        shaped_d.valid   = decoded.valid;
        shaped_d.clipped = 1'b0;
        case (decoded.region)
            REGION_CLIP_HIGH: begin
                shaped_d.sample  = $signed(decoded.limit);
                shaped_d.clipped = 1'b1;
            end
            REGION_CLIP_LOW: begin
                shaped_d.sample  = -$signed(decoded.limit);
                shaped_d.clipped = 1'b1;
            end
            REGION_CROSS: begin
                // software keeps threshold times two to the shift in range.
                shaped_d.sample = decoded.sample <<< decoded.shift;
            end
            default: begin
                shaped_d.sample = decoded.sample;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            shaped.valid <= 1'b0;
        end else if (advance) begin
            shaped <= shaped_d;
        end
    end

endmodule

`default_nettype wire

// File: design/dist_region_decode.sv
`timescale 1ns/1ns
`default_nettype none

module dist_region_decode import dist_sample_pkg::*, dist_regs_pkg::*; (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       advance,
    input  wire logic signed [SAMPLE_W-1:0] s_tdata,
    input  wire logic                       s_tvalid,
    input  wire dist_cfg_t                  cfg,
    output dist_decoded_t                   decoded
);

    // one extra bit lets the unsigned settings and their negatives be
    // compared against the signed sample without overflow.
    logic signed [SAMPLE_W:0] sample_ext;
    logic signed [SAMPLE_W:0] limit_ext;
    logic signed [SAMPLE_W:0] thresh_ext;
    dist_region_e             region_d;
    dist_decoded_t            decoded_d;

    assign sample_ext = {s_tdata[SAMPLE_W-1], s_tdata};
    assign limit_ext  = {1'b0, cfg.high_clip};
    assign thresh_ext = {1'b0, cfg.cross_thresh};

    // clipping wins over crossover when the two windows overlap.
    always_comb begin
        if (sample_ext > limit_ext) begin
            region_d = REGION_CLIP_HIGH;
        end else if (sample_ext < -limit_ext) begin
            region_d = REGION_CLIP_LOW;
        end else if (cfg.cross_en && (sample_ext < thresh_ext) &&
                     (sample_ext > -thresh_ext)) begin
            region_d = REGION_CROSS;
        end else begin
            region_d = REGION_PASS;
        end
    end

    always_comb begin
        decoded_d.valid  = s_tvalid;
        decoded_d.sample = s_tdata;
        decoded_d.region = region_d;
        decoded_d.limit  = cfg.high_clip;
        decoded_d.shift  = cfg.cross_shift;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded.valid <= 1'b0;
        end else if (advance) begin
            decoded <= decoded_d;
        end
    end

endmodule

`default_nettype wire

// File: design/dist_csr.sv
`timescale 1ns/1ns
`default_nettype none

module dist_csr import dist_regs_pkg::*; #(
    parameter logic [DATA_W-1:0] DEFAULT_HIGH_CLIP    = 32'h0010_0000,
    parameter logic [DATA_W-1:0] DEFAULT_CROSS_THRESH = 32'h0000_1000,
    parameter logic [2:0]        DEFAULT_CROSS_SHIFT  = 3'd4
) (
    input  wire logic              clk,
    input  wire logic              reset,

    input  wire logic [ADDR_W-1:0] awaddr,
    input  wire logic              awvalid,
    output logic                   awready,
    input  wire logic [DATA_W-1:0] wdata,
    input  wire logic [STRB_W-1:0] wstrb,
    input  wire logic              wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  wire logic              bready,

    input  wire logic [ADDR_W-1:0] araddr,
    input  wire logic              arvalid,
    output logic                   arready,
    output logic [DATA_W-1:0]      rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  wire logic              rready,

    output dist_cfg_t              cfg,
    input  wire logic              clip_event
);

    wr_state_e         wr_state;
    rd_state_e         rd_state;
    dist_cfg_t         cfg_q;
    logic [DATA_W-1:0] clip_count;
    logic              wr_fire;
    logic              wr_err;
    logic              rd_fire;
    logic [DATA_W-1:0] rd_data_d;
    logic              rd_err;

    // merges a write into an existing register one byte lane at a time.
    function automatic logic [DATA_W-1:0] merge_strb(input logic [DATA_W-1:0] old_val,
                                                     input logic [DATA_W-1:0] new_val,
                                                     input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old_val;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    // address and data are taken together, and only with no response pending.
    assign wr_fire = awvalid && wvalid && (wr_state == WR_IDLE);
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign bvalid  = (wr_state == WR_RESP);

    // The count register is read only, so a write to it is an error as well.
    assign wr_err = !((awaddr == REG_CTRL) || (awaddr == REG_HIGH_CLIP) ||
                      (awaddr == REG_CROSS_THRESH) || (awaddr == REG_CROSS_SHIFT));

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_state <= WR_IDLE;
        end else if (wr_state == WR_IDLE) begin
            if (wr_fire) begin
                wr_state <= WR_RESP;
            end
        end else if (bready) begin
            wr_state <= WR_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q.cross_en     <= 1'b1;
            cfg_q.high_clip    <= DEFAULT_HIGH_CLIP;
            cfg_q.cross_thresh <= DEFAULT_CROSS_THRESH;
            cfg_q.cross_shift  <= DEFAULT_CROSS_SHIFT;
        end else if (wr_fire) begin
            case (awaddr)
                REG_CTRL: begin
                    if (wstrb[0]) begin
                        cfg_q.cross_en <= wdata[0];
                    end
                end
                REG_HIGH_CLIP:    cfg_q.high_clip <= merge_strb(cfg_q.high_clip, wdata, wstrb);
                REG_CROSS_THRESH: begin
                    cfg_q.cross_thresh <= merge_strb(cfg_q.cross_thresh, wdata, wstrb);
                end
                REG_CROSS_SHIFT: begin
                    if (wstrb[0]) begin
                        cfg_q.cross_shift <= wdata[2:0];
                    end
                end
                default: ;
            endcase
        end
    end

    assign cfg = cfg_q;

    // wraps naturally at the register width.
    always_ff @(posedge clk) begin
        if (reset) begin
            clip_count <= '0;
        end else if (clip_event) begin
            clip_count <= clip_count + 1'b1;
        end
    end

    assign arready = (rd_state == RD_IDLE);
    assign rvalid  = (rd_state == RD_DATA);
    assign rd_fire = arvalid && arready;

    always_comb begin
        rd_data_d = '0;
        rd_err    = 1'b0;
        case (araddr)
            REG_CTRL:         rd_data_d = {{(DATA_W-1){1'b0}}, cfg_q.cross_en};
            REG_HIGH_CLIP:    rd_data_d = cfg_q.high_clip;
            REG_CROSS_THRESH: rd_data_d = cfg_q.cross_thresh;
            REG_CROSS_SHIFT:  rd_data_d = {{(DATA_W-3){1'b0}}, cfg_q.cross_shift};
            REG_CLIP_COUNT:   rd_data_d = clip_count;
            default:          rd_err    = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_state <= RD_IDLE;
        end else if (rd_state == RD_IDLE) begin
            if (rd_fire) begin
                rd_state <= RD_DATA;
            end
        end else if (rready) begin
            rd_state <= RD_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_data_d;
            rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// File: design/dist_regs_pkg.sv
`default_nettype none

package dist_regs_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // byte offsets of the register map.
    localparam logic [ADDR_W-1:0] REG_CTRL         = 8'h00;
    localparam logic [ADDR_W-1:0] REG_HIGH_CLIP    = 8'h04;
    localparam logic [ADDR_W-1:0] REG_CROSS_THRESH = 8'h08;
    localparam logic [ADDR_W-1:0] REG_CROSS_SHIFT  = 8'h0C;
    localparam logic [ADDR_W-1:0] REG_CLIP_COUNT   = 8'h10;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // run-time settings where high_clip is an unsigned magnitude.
    typedef struct packed {
        logic              cross_en;
        logic [DATA_W-1:0] high_clip;
        logic [DATA_W-1:0] cross_thresh;
        logic [2:0]        cross_shift;
    } dist_cfg_t;

    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } wr_state_e;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_e;

endpackage

`default_nettype wire

// File: design/dist_sample_pkg.sv
`default_nettype none

package dist_sample_pkg;

    // width of one audio sample on both stream ports.
    localparam int SAMPLE_W = 32;

    // region opcode chosen by the decode stage and executed by the shaper.
    typedef enum logic [1:0] {
        REGION_PASS      = 2'd0,
        REGION_CLIP_HIGH = 2'd1,
        REGION_CLIP_LOW  = 2'd2,
        REGION_CROSS     = 2'd3
    } dist_region_e;

    // decode to shaper.
    // The limit and the shift travel with the sample, so a settings change
    // never affects samples that are already in flight.
    typedef struct packed {
        logic                       valid;
        logic signed [SAMPLE_W-1:0] sample;
        dist_region_e               region;
        logic [SAMPLE_W-1:0]        limit;
        logic [2:0]                 shift;
    } dist_decoded_t;

    // shaper to output stage.
    typedef struct packed {
        logic                       valid;
        logic signed [SAMPLE_W-1:0] sample;
        logic                       clipped;
    } dist_shaped_t;

endpackage

`default_nettype wire
